// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = serdes_tb
FILELIST = build.f
OBJDIR   = obj_dir
LOG      = sim.log
PASS_MSG = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== build.f ====
rtl/serdes_pkg.sv
rtl/prbs_gen.sv
rtl/pam4_tx.sv
rtl/coef_loader.sv
rtl/isi_channel.sv
rtl/dfe_slicer.sv
rtl/gray_rx.sv
rtl/link_monitor.sv
rtl/serdes_top.sv
sim/serdes_tb.sv

// ==== rtl/coef_loader.sv ====
`timescale 1ns/1ps

module coef_loader import serdes_pkg::*; (
    input  logic     clock,
    input  logic     reset_n,
    input  logic     load_start,   // pulse, only honoured in wait
    input  logic     coef_wr,
    input  tap_idx_t coef_addr,
    input  coef_t    coef_wdata,
    output logic     tap_load,
    output tap_idx_t tap_loc,
    output coef_t    tap_data,
    output logic     coef_ready
);

    typedef enum logic [1:0] {
        ST_WAIT = 2'b00,  // idle until load_start
        ST_LOAD = 2'b01,  // stream one tap per cycle
        ST_DONE = 2'b10   // parked, link running
    } load_state_t;

    load_state_t state;
    coef_t       coef_mem [N_TAPS];

    // outside write port, open at any time
    always_ff @(posedge clock) begin
        if (coef_wr)
            coef_mem[coef_addr] <= coef_wdata;
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state      <= ST_WAIT;
            tap_load   <= 1'b0;
            tap_loc    <= '0;
            coef_ready <= 1'b0;
        end else begin
            case (state)
                ST_WAIT: begin
                    if (load_start) begin
                        state    <= ST_LOAD;
                        tap_load <= 1'b1;
                        tap_loc  <= '0;  // start at first post-cursor
                    end
                end
                ST_LOAD: begin
                    if (tap_loc == tap_idx_t'(N_TAPS - 1)) begin
                        state      <= ST_DONE;
                        tap_load   <= 1'b0;
                        coef_ready <= 1'b1;  // cycle after last load
                    end else begin
                        tap_loc <= tap_loc + 1'b1;
                    end
                end
                ST_DONE: state <= ST_DONE;  // stays until reset, load_start ignored
                default: state <= ST_WAIT;
            endcase
        end
    end

    // entry at the current location, valid while tap_load
    assign tap_data = coef_mem[tap_loc];

endmodule

// ==== rtl/dfe_slicer.sv ====
`timescale 1ns/1ps

module dfe_slicer import serdes_pkg::*; (
    input  logic     clock,
    input  logic     reset_n,
    input  logic     tap_load,
    input  tap_idx_t tap_loc,
    input  coef_t    tap_data,
    input  level_t   chan_level,
    input  logic     chan_valid,
    output symbol_t  rx_symbol,
    output logic     rx_symbol_valid
);

    coef_t   taps [N_TAPS];   // own copy of h1, h2
    level_t  dec  [N_TAPS];   // d1, d2 decided levels
    logic signed [15:0] acc;
    level_t  eq_level;        // equalized sample
    symbol_t slice_sym;
    level_t  slice_level;

    always_comb begin
        acc      = chan_level;
        acc      = acc - isi_sum(taps, dec);  // cancel post-cursor isi
        eq_level = clamp_level(acc);

        // thresholds at -sep, 0, +sep
        if (eq_level >= SYMBOL_SEPARATION)
            slice_sym = 2'b10;
        else if (eq_level >= 0)
            slice_sym = 2'b11;
        else if (eq_level >= -SYMBOL_SEPARATION)
            slice_sym = 2'b01;
        else
            slice_sym = 2'b00;

        slice_level = gray_to_level(slice_sym);  // ideal level for feedback
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            for (int i = 0; i < N_TAPS; i++) begin
                taps[i] <= '0;
                dec[i]  <= '0;
            end
            rx_symbol_valid <= 1'b0;
        end else begin
            rx_symbol_valid <= chan_valid;
            if (tap_load)
                taps[tap_loc] <= tap_data;
            if (chan_valid) begin
                dec[0] <= slice_level;
                for (int i = 1; i < N_TAPS; i++)
                    dec[i] <= dec[i-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (chan_valid)
            rx_symbol <= slice_sym;
    end

endmodule

// ==== rtl/gray_rx.sv ====
`timescale 1ns/1ps

module gray_rx import serdes_pkg::*; (
    input  logic    clock,
    input  logic    reset_n,
    input  symbol_t rx_symbol,
    input  logic    rx_symbol_valid,
    output logic    rx_bit,
    output logic    rx_valid
);

    // the pam4 map carries the gray code, so symbol bits are the data bits
    logic pending;   // lower bit still to send
    logic low_bit;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            pending  <= 1'b0;
            rx_valid <= 1'b0;
        end else begin
            if (rx_symbol_valid) begin
                pending  <= 1'b1;
                rx_valid <= 1'b1;  // upper bit cycle
            end else if (pending) begin
                pending  <= 1'b0;
                rx_valid <= 1'b1;  // lower bit cycle
            end else begin
                rx_valid <= 1'b0;
            end
        end
    end

    // symbols are at least two cycles apart, no overlap with pending
    always_ff @(posedge clock) begin
        if (rx_symbol_valid) begin
            rx_bit  <= rx_symbol[1];  // msb first
            low_bit <= rx_symbol[0];
        end else if (pending) begin
            rx_bit <= low_bit;
        end
    end

endmodule

// ==== rtl/isi_channel.sv ====
`timescale 1ns/1ps

module isi_channel import serdes_pkg::*; (
    input  logic     clock,
    input  logic     reset_n,
    input  logic     tap_load,
    input  tap_idx_t tap_loc,
    input  coef_t    tap_data,
    input  level_t   tx_level,
    input  logic     tx_level_valid,
    output level_t   chan_level,
    output logic     chan_valid
);

    coef_t  taps [N_TAPS];   // h1, h2
    level_t hist [N_TAPS];   // x1, x2 previous inputs
    logic signed [15:0] acc;

    // x + h1*x1 + h2*x2, each term scaled
    always_comb begin
        acc = tx_level;                 // sign extends
        acc = acc + isi_sum(taps, hist);
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            for (int i = 0; i < N_TAPS; i++) begin
                taps[i] <= '0;
                hist[i] <= '0;
            end
            chan_valid <= 1'b0;
        end else begin
            chan_valid <= tx_level_valid;  // one cycle latency
            if (tap_load)
                taps[tap_loc] <= tap_data;
            if (tx_level_valid) begin
                hist[0] <= tx_level;
                for (int i = 1; i < N_TAPS; i++)
                    hist[i] <= hist[i-1];  // shift history
            end
        end
    end

    always_ff @(posedge clock) begin
        if (tx_level_valid)
            chan_level <= clamp_level(acc);  // +-LEVEL_MAX
    end

endmodule

// ==== rtl/link_monitor.sv ====
`timescale 1ns/1ps

module link_monitor import serdes_pkg::*; (
    input  logic       clock,
    input  logic       reset_n,
    input  logic       rx_valid,
    output bit_count_t bit_count,
    output logic       target_reached
);

    logic last_bit;   // this pulse completes the target

    assign last_bit = (bit_count == bit_count_t'(BIT_TARGET - 1));

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            bit_count      <= '0;
            target_reached <= 1'b0;
        end else if (rx_valid && !target_reached) begin
            bit_count <= bit_count + 1'b1;  // frozen once target hit
            if (last_bit)
                target_reached <= 1'b1;      // sticky until reset
        end
    end

endmodule

// ==== rtl/pam4_tx.sv ====
`timescale 1ns/1ps

module pam4_tx import serdes_pkg::*; (
    input  logic   clock,
    input  logic   reset_n,
    input  logic   tx_bit,
    input  logic   tx_bit_valid,
    output level_t tx_level,
    output logic   tx_level_valid
);

    logic    half;       // upper bit captured, waiting for lower
    logic    upper_bit;
    symbol_t symbol;

    // first bit of a pair is the msb
    assign symbol = {upper_bit, tx_bit};

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            half           <= 1'b0;
            tx_level_valid <= 1'b0;
        end else begin
            tx_level_valid <= 1'b0;
            if (tx_bit_valid) begin
                if (!half) begin
                    half <= 1'b1;
                end else begin
                    half           <= 1'b0;
                    tx_level_valid <= 1'b1;  // one cycle after second bit
                end
            end
            // no valid -> pair state simply held across the pause
        end
    end

    // payload side
    always_ff @(posedge clock) begin
        if (tx_bit_valid && !half)
            upper_bit <= tx_bit;
        if (tx_bit_valid && half)
            tx_level <= gray_to_level(symbol);  // gray pair straight to level
    end

endmodule

// ==== rtl/prbs_gen.sv ====
`timescale 1ns/1ps

module prbs_gen import serdes_pkg::*; (
    input  logic clock,
    input  logic reset_n,
    input  logic run,          // level enable from outside
    input  logic coef_ready,   // taps loaded, link may run
    output logic tx_bit,
    output logic tx_bit_valid
);

    logic [6:0] lfsr;
    logic       feedback;
    logic       advance;

    // x^7 + x^6 + 1
    assign feedback = lfsr[6] ^ lfsr[5];
    assign advance  = run && coef_ready;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            lfsr         <= PRBS_SEED;
            tx_bit_valid <= 1'b0;
        end else begin
            tx_bit_valid <= advance;
            if (advance)
                lfsr <= {lfsr[5:0], feedback};  // holds on pause, no restart
        end
    end

    // emitted bit is the one shifted in
    always_ff @(posedge clock) begin
        if (advance)
            tx_bit <= feedback;
    end

endmodule

// ==== rtl/serdes_pkg.sv ====
package serdes_pkg;

    // link geometry
    localparam int N_TAPS            = 2;    // post-cursor taps
    localparam int COEF_SHIFT        = 6;    // coefficients in 1/64 units
    localparam int SYMBOL_SEPARATION = 56;   // level spacing, also slicer threshold
    localparam int LEVEL_MAX         = 127;  // symmetric clamp bound
    localparam int LEVEL_OUTER       = 84;
    localparam int LEVEL_INNER       = 28;
    localparam int BIT_TARGET        = 512;  // monitor completion count
    localparam logic [6:0] PRBS_SEED = 7'h7f;

    typedef logic signed [7:0] level_t;     // voltage sample
    typedef logic        [1:0] symbol_t;    // gray coded pam4 symbol
    typedef logic signed [7:0] coef_t;      // tap weight
    typedef logic        [0:0] tap_idx_t;   // tap location
    typedef logic        [9:0] bit_count_t;

    // gray symbol -> pam4 level, adjacent levels differ in one bit
    function automatic level_t gray_to_level(symbol_t sym);
        case (sym)
            2'b00:   return level_t'(-LEVEL_OUTER);
            2'b01:   return level_t'(-LEVEL_INNER);
            2'b11:   return level_t'(LEVEL_INNER);
            default: return level_t'(LEVEL_OUTER);  // 2'b10
        endcase
    endfunction

    // sum of scaled post-cursor contributions, h[i] * x[i] >>> shift
    function automatic logic signed [15:0] isi_sum(input coef_t taps [N_TAPS],
                                                   input level_t hist [N_TAPS]);
        logic signed [15:0] prod;
        logic signed [15:0] acc;
        acc = '0;
        for (int i = 0; i < N_TAPS; i++) begin
            prod = taps[i] * hist[i];               // 16 bit signed product
            acc  = acc + (prod >>> COEF_SHIFT);     // arithmetic scale
        end
        return acc;
    endfunction

    // saturate a wide sum back into the level range
    function automatic level_t clamp_level(logic signed [15:0] v);
        if (v > LEVEL_MAX)
            return level_t'(LEVEL_MAX);
        else if (v < -LEVEL_MAX)
            return level_t'(-LEVEL_MAX);
        else
            return v[7:0];
    endfunction

endpackage

// ==== rtl/serdes_top.sv ====
`timescale 1ns/1ps

module serdes_top import serdes_pkg::*; (
    input  logic       clock,
    input  logic       reset_n,
    input  logic       run,
    input  logic       load_start,
    input  logic       coef_wr,
    input  tap_idx_t   coef_addr,
    input  coef_t      coef_wdata,
    output logic       coef_ready,
    output level_t     chan_level,
    output logic       chan_valid,
    output logic       rx_bit,
    output logic       rx_valid,
    output bit_count_t bit_count,
    output logic       target_reached
);

    // tap distribution
    logic     tap_load;
    tap_idx_t tap_loc;
    coef_t    tap_data;

    // tx side
    logic     tx_bit;
    logic     tx_bit_valid;
    level_t   tx_level;
    logic     tx_level_valid;

    // rx side
    symbol_t  rx_symbol;
    logic     rx_symbol_valid;

    coef_loader coef_loader_inst (
        .clock      (clock),
        .reset_n    (reset_n),
        .load_start (load_start),
        .coef_wr    (coef_wr),
        .coef_addr  (coef_addr),
        .coef_wdata (coef_wdata),
        .tap_load   (tap_load),
        .tap_loc    (tap_loc),
        .tap_data   (tap_data),
        .coef_ready (coef_ready)
    );

    prbs_gen prbs_gen_inst (
        .clock        (clock),
        .reset_n      (reset_n),
        .run          (run),
        .coef_ready   (coef_ready),   // link held until taps loaded
        .tx_bit       (tx_bit),
        .tx_bit_valid (tx_bit_valid)
    );

    pam4_tx pam4_tx_inst (
        .clock          (clock),
        .reset_n        (reset_n),
        .tx_bit         (tx_bit),
        .tx_bit_valid   (tx_bit_valid),
        .tx_level       (tx_level),
        .tx_level_valid (tx_level_valid)
    );

    isi_channel isi_channel_inst (
        .clock          (clock),
        .reset_n        (reset_n),
        .tap_load       (tap_load),
        .tap_loc        (tap_loc),
        .tap_data       (tap_data),
        .tx_level       (tx_level),
        .tx_level_valid (tx_level_valid),
        .chan_level     (chan_level),
        .chan_valid     (chan_valid)
    );

    dfe_slicer dfe_slicer_inst (
        .clock           (clock),
        .reset_n         (reset_n),
        .tap_load        (tap_load),   // same taps as the channel
        .tap_loc         (tap_loc),
        .tap_data        (tap_data),
        .chan_level      (chan_level),
        .chan_valid      (chan_valid),
        .rx_symbol       (rx_symbol),
        .rx_symbol_valid (rx_symbol_valid)
    );

    gray_rx gray_rx_inst (
        .clock           (clock),
        .reset_n         (reset_n),
        .rx_symbol       (rx_symbol),
        .rx_symbol_valid (rx_symbol_valid),
        .rx_bit          (rx_bit),
        .rx_valid        (rx_valid)
    );

    link_monitor link_monitor_inst (
        .clock          (clock),
        .reset_n        (reset_n),
        .rx_valid       (rx_valid),
        .bit_count      (bit_count),
        .target_reached (target_reached)
    );

endmodule

// ==== sim/serdes_tb.sv ====
`timescale 1ns/1ps

module serdes_tb import serdes_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int SEED         = 32'h1823_ae10;
    localparam int PIPE_DEPTH   = 6;   // negedges from run low to last rx_valid
    localparam int EXTRA_BITS   = 64;  // keep running past the target
    localparam int LOAD_TIMEOUT = 20;
    localparam int WATCHDOG_NS  = (BIT_TARGET * 4 + 600) * CLK_PERIOD;

    localparam int T_RESET  = 0;
    localparam int T_IDLE   = 1;
    localparam int T_LOAD   = 2;
    localparam int T_RELOAD = 3;
    localparam int T_CHAN   = 4;
    localparam int T_BITS   = 5;
    localparam int T_PAUSE  = 6;
    localparam int T_MON    = 7;
    localparam int N_TESTS  = 8;

    logic       clock;
    logic       reset_n;
    logic       run;
    logic       load_start;
    logic       coef_wr;
    tap_idx_t   coef_addr;
    coef_t      coef_wdata;
    logic       coef_ready;
    level_t     chan_level;
    logic       chan_valid;
    logic       rx_bit;
    logic       rx_valid;
    bit_count_t bit_count;
    logic       target_reached;

    // model state
    int         h [N_TAPS];            // loaded coefficients
    int         x1 = 0;                // channel history
    int         x2 = 0;
    logic [6:0] model_lfsr = PRBS_SEED;
    int         exp_bits [$];          // bits sent and still in flight
    int         rx_seen = 0;
    int         chan_seen = 0;
    int         errs [N_TESTS] = '{default: 0};
    string      test_names [N_TESTS] = '{"reset_state", "no_traffic_before_load",
        "load_timing", "reload_ignored", "channel_samples", "bit_recovery",
        "pauses", "monitor"};

    serdes_top serdes_top_inst (
        .clock          (clock),
        .reset_n        (reset_n),
        .run            (run),
        .load_start     (load_start),
        .coef_wr        (coef_wr),
        .coef_addr      (coef_addr),
        .coef_wdata     (coef_wdata),
        .coef_ready     (coef_ready),
        .chan_level     (chan_level),
        .chan_valid     (chan_valid),
        .rx_bit         (rx_bit),
        .rx_valid       (rx_valid),
        .bit_count      (bit_count),
        .target_reached (target_reached)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // x^7 + x^6 + 1 with the new bit shifted in at the bottom
    function automatic int next_prbs_bit();
        logic fb;
        fb         = model_lfsr[6] ^ model_lfsr[5];
        model_lfsr = {model_lfsr[5:0], fb};
        return int'(fb);
    endfunction

    function automatic int level_of_symbol(int hi, int lo);
        case ({hi[0], lo[0]})
            2'b00:   return -LEVEL_OUTER;
            2'b01:   return -LEVEL_INNER;
            2'b11:   return LEVEL_INNER;
            default: return LEVEL_OUTER;
        endcase
    endfunction

    function automatic int saturate(int v);
        if (v > LEVEL_MAX)
            return LEVEL_MAX;
        if (v < -LEVEL_MAX)
            return -LEVEL_MAX;
        return v;
    endfunction

    // y = x + (h1*x1 >>> 6) + (h2*x2 >>> 6) clamped to the level range
    function automatic int channel_output(int x);
        int y;
        y = x + ((h[0] * x1) >>> COEF_SHIFT) + ((h[1] * x2) >>> COEF_SHIFT);
        return saturate(y);
    endfunction

    task automatic report_mismatch(int t, int expected, int actual);
        $display("ERROR %s: expected %0d, actual %0d", test_names[t], expected, actual);
        errs[t]++;
    endtask

    task automatic flag_failure(int t, string what);
        $display("%s: %s", test_names[t], what);
        errs[t]++;
    endtask

    task automatic print_test_result(int t);
        $display("test %-24s %s (%0d errors)", test_names[t],
                 (errs[t] == 0) ? "ok" : "FAIL", errs[t]);
    endtask

    // output checker sampling at negedge where everything is settled
    initial begin : link_checker
        int hi;
        int lo;
        int x;
        int exp_count;
        int low_cycles;
        low_cycles = 0;
        wait (reset_n === 1'b1);
        forever begin
            @(negedge clock);
            // counter lags rx_valid by one cycle
            exp_count = (rx_seen < BIT_TARGET) ? rx_seen : BIT_TARGET;
            assert (int'(bit_count) == exp_count)
                else report_mismatch(T_MON, exp_count, int'(bit_count));
            assert (int'(target_reached) == int'(rx_seen >= BIT_TARGET))
                else report_mismatch(T_MON, int'(rx_seen >= BIT_TARGET), int'(target_reached));
            if (chan_valid) begin
                hi = next_prbs_bit();  // upper bit first
                lo = next_prbs_bit();
                exp_bits.push_back(hi);
                exp_bits.push_back(lo);
                x = level_of_symbol(hi, lo);
                assert (int'(chan_level) == channel_output(x))
                    else report_mismatch(T_CHAN, channel_output(x), int'(chan_level));
                x2 = x1;
                x1 = x;
                chan_seen++;
            end
            if (rx_valid) begin
                if (exp_bits.size() == 0) begin
                    flag_failure(T_BITS, "rx_valid with no bit sent");
                end else begin
                    hi = exp_bits.pop_front();
                    assert (int'(rx_bit) == hi) else report_mismatch(T_BITS, hi, int'(rx_bit));
                end
                rx_seen++;
            end
            // drain window after run drops
            if (run)
                low_cycles = 0;
            else
                low_cycles++;
            assert (!(rx_valid && low_cycles > PIPE_DEPTH))
                else flag_failure(T_PAUSE, "rx_valid long after run fell");
        end
    end

    initial begin : stimulus
        int cycles;
        int total_errs;
        int ok_tests;
        void'($urandom(SEED));
        reset_n    = 1'b0;
        run        = 1'b0;
        load_start = 1'b0;
        coef_wr    = 1'b0;
        coef_addr  = '0;
        coef_wdata = '0;
        repeat (3) @(posedge clock);
        reset_n <= 1'b1;

        @(negedge clock);
        assert (coef_ready == 1'b0) else report_mismatch(T_RESET, 0, int'(coef_ready));
        assert (chan_valid == 1'b0) else report_mismatch(T_RESET, 0, int'(chan_valid));
        assert (rx_valid == 1'b0) else report_mismatch(T_RESET, 0, int'(rx_valid));
        assert (target_reached == 1'b0) else report_mismatch(T_RESET, 0, int'(target_reached));
        assert (bit_count == '0) else report_mismatch(T_RESET, 0, int'(bit_count));
        print_test_result(T_RESET);

        // run alone must not start the link
        @(posedge clock);
        run <= 1'b1;
        repeat (50) begin
            @(negedge clock);
            assert (!chan_valid) else flag_failure(T_IDLE, "chan_valid before load");
            assert (!rx_valid) else flag_failure(T_IDLE, "rx_valid before load");
        end
        print_test_result(T_IDLE);

        for (int i = 0; i < N_TAPS; i++) begin
            h[i] = int'($urandom_range(32)) - 16;  // -16..+16 keeps clear of the clamp
            @(posedge clock);
            coef_wr    <= 1'b1;
            coef_addr  <= tap_idx_t'(i);
            coef_wdata <= coef_t'(h[i]);
        end
        @(posedge clock);
        coef_wr    <= 1'b0;
        load_start <= 1'b1;
        @(posedge clock);
        load_start <= 1'b0;  // this edge is the one that sees the pulse
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (!coef_ready && cycles < LOAD_TIMEOUT);
        if (!coef_ready)
            flag_failure(T_LOAD, "coef_ready never rose after load_start");
        else
            assert (cycles == N_TAPS + 1) else report_mismatch(T_LOAD, N_TAPS + 1, cycles);
        print_test_result(T_LOAD);

        // late write plus second load that the channel check would expose
        @(posedge clock);
        coef_wr    <= 1'b1;
        coef_addr  <= '0;
        coef_wdata <= coef_t'(h[0] + 40);
        @(posedge clock);
        coef_wr    <= 1'b0;
        load_start <= 1'b1;
        @(posedge clock);
        load_start <= 1'b0;
        repeat (10) begin
            @(negedge clock);
            assert (coef_ready) else flag_failure(T_RELOAD, "coef_ready dropped");
        end
        print_test_result(T_RELOAD);

        // random run bursts and pauses
        @(posedge clock);
        while (rx_seen < BIT_TARGET + EXTRA_BITS) begin
            run <= 1'b1;
            repeat ($urandom_range(20, 1)) @(posedge clock);
            run <= 1'b0;
            repeat ($urandom_range(10, 1)) @(posedge clock);
        end
        run <= 1'b0;
        repeat (2 * PIPE_DEPTH) @(posedge clock);  // drain

        assert (chan_seen > 0) else flag_failure(T_CHAN, "no channel samples seen");
        print_test_result(T_CHAN);
        assert (exp_bits.size() == 0) else report_mismatch(T_BITS, 0, exp_bits.size());
        print_test_result(T_BITS);
        print_test_result(T_PAUSE);
        @(negedge clock);
        assert (int'(bit_count) == BIT_TARGET)
            else report_mismatch(T_MON, BIT_TARGET, int'(bit_count));
        assert (target_reached)
            else flag_failure(T_MON, "target_reached low at the end of the run");
        print_test_result(T_MON);

        total_errs = 0;
        ok_tests   = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            total_errs += errs[t];
            if (errs[t] == 0)
                ok_tests++;
        end
        $display("summary: %0d of %0d ok, %0d errors, %0d bits received",
                 ok_tests, N_TESTS, total_errs, rx_seen);
        if (total_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // bounded by the bit target at four cycles per bit
    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, link did not finish", WATCHDOG_NS);
        $display("tests failed");
        $finish;
    end

endmodule
